//--- dcache2w.f
logic/cacheGeomPkg.sv
logic/cacheBusPkg.sv
logic/tagStore.sv
logic/lineStore.sv
logic/wbMemPort.sv
logic/cacheCtrl.sv
logic/dcache2wTop.sv
tests/tbClock.sv
tests/wbMemModel.sv
tests/dcache2w_assertions.sv
tests/dcache2wTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module dcache2wTb -f dcache2w.f -o dcache2wSim &&
  ./obj_dir/dcache2wSim ||
  { echo "dcache2w simulation failed"; exit 1; }

//--- tests/dcache2wTb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache2wTb;

  import cacheGeomPkg::*;
  import cacheBusPkg::*;

  localparam int MemWords     = 2048;
  localparam int MemIdxBits   = $clog2(MemWords);
  localparam int StepTimeout  = 200;
  localparam int DrainTimeout = 400;
  localparam int RandomOps    = 300;

  logic                 clk;
  logic                 rst_n;
  logic                 reqValid;
  opT                   reqOp;
  logic [AddrWidth-1:0] reqAddr;
  wordT                 reqData;
  maskT                 reqMask;
  logic                 addrOk;
  logic                 dataOk;
  wordT                 rdData;
  logic                 wbCyc;
  logic                 wbStb;
  logic                 wbWe;
  logic [AddrWidth-1:0] wbAdr;
  wordT                 busWrDat;
  wordT                 busRdDat;
  maskT                 wbSel;
  logic                 wbAck;
  int                   bursts;
  int                   readBeats;
  logic [AddrWidth-1:0] lastWrAdr;
  wordT                 lastWrDat;
  maskT                 lastWrSel;

  // shadow memory and shadow tag/LRU state of the two ways
  wordT shadowMem   [MemWords];
  tagT  shadowTag   [Sets][2];
  logic shadowValid [Sets][2];
  logic shadowLru   [Sets];

  wordT expData   [$];
  bit   expIsRead [$];
  int   respCount = 0;
  int   expRefills;

  tbClock #(.HalfPeriod(2), .ResetCycles(3)) clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dcache2wTop dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (reqValid),
    .op_i     (reqOp),
    .addr_i   (reqAddr),
    .wrData_i (reqData),
    .wrMask_i (reqMask),
    .addrOk_o (addrOk),
    .dataOk_o (dataOk),
    .rdData_o (rdData),
    .wbCyc_o  (wbCyc),
    .wbStb_o  (wbStb),
    .wbWe_o   (wbWe),
    .wbAdr_o  (wbAdr),
    .wbDat_o  (busWrDat),
    .wbSel_o  (wbSel),
    .wbDat_i  (busRdDat),
    .wbAck_i  (wbAck)
  );

  wbMemModel #(.Words(MemWords)) mem_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wbCyc_i     (wbCyc),
    .wbStb_i     (wbStb),
    .wbWe_i      (wbWe),
    .wbAdr_i     (wbAdr),
    .wbDat_i     (busWrDat),
    .wbSel_i     (wbSel),
    .wbDat_o     (busRdDat),
    .wbAck_o     (wbAck),
    .bursts_o    (bursts),
    .readBeats_o (readBeats),
    .lastWrAdr_o (lastWrAdr),
    .lastWrDat_o (lastWrDat),
    .lastWrSel_o (lastWrSel)
  );

  function automatic wordT patternWord(input logic [AddrWidth-1:0] byteAddr);
    return {byteAddr ^ 32'h5EED_F00D, ~byteAddr};
  endfunction

  // expected read data, plus whether a read has to refill its line
  function automatic wordT predictResponse(input opT op, input logic [AddrWidth-1:0] addr,
                                           input wordT data, input maskT mask,
                                           output logic refills);
    indexT setIdx;
    tagT   tag;
    int    wIdx;
    int    hitWay;
    int    victim;
    setIdx  = addr[OffsetBits +: IndexBits];
    tag     = addr[AddrWidth-1 -: TagBits];
    wIdx    = int'(addr[3 +: MemIdxBits]);
    hitWay  = -1;
    refills = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (shadowValid[setIdx][w] && shadowTag[setIdx][w] == tag) begin
        hitWay = w;
      end
    end
    if (hitWay >= 0) begin
      shadowLru[setIdx] = (hitWay == 0);
    end else if (op == opRead) begin
      refills = 1'b1;
      if (!shadowValid[setIdx][0]) begin
        victim = 0;
      end else if (!shadowValid[setIdx][1]) begin
        victim = 1;
      end else begin
        victim = shadowLru[setIdx] ? 1 : 0;
      end
      shadowValid[setIdx][victim] = 1'b1;
      shadowTag[setIdx][victim]   = tag;
      shadowLru[setIdx]           = (victim == 0);
    end
    // write-through, so memory always holds the merged word
    if (op == opWrite) begin
      for (int b = 0; b < MaskWidth; b++) begin
        if (mask[b]) begin
          shadowMem[wIdx][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
    return shadowMem[wIdx];
  endfunction

  task automatic stopRun();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
      stopRun();
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic sendReq(input opT op, input logic [AddrWidth-1:0] addr, input wordT data,
                         input maskT mask, output int stall);
    wordT expWord;
    logic refilled;
    stall    = 0;
    reqValid = 1'b1;
    reqOp    = op;
    reqAddr  = addr;
    reqData  = data;
    reqMask  = mask;
    while (!addrOk && stall < StepTimeout) begin
      @(negedge clk);
      stall++;
    end
    if (!addrOk) begin
      $display("Request to %h was not accepted within %0d cycles", addr, StepTimeout);
      stopRun();
    end else begin
      @(posedge clk);
      expWord = predictResponse(op, addr, data, mask, refilled);
      expData.push_back(expWord);
      expIsRead.push_back(op == opRead);
      if (refilled) begin
        expRefills++;
      end
      @(negedge clk);
      reqValid = 1'b0;
    end
  endtask

  task automatic drainResponses();
    int waited;
    waited = 0;
    while (respCount < expIsRead.size() && waited < DrainTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (respCount < expIsRead.size()) begin
      $display("Responses still missing after %0d cycles", DrainTimeout);
      stopRun();
    end
  endtask

  task automatic checkRefills();
    checkEq("refill bursts", 64'(bursts), 64'(expRefills));
    checkEq("refill beats", 64'(readBeats), 64'(4 * expRefills));
  endtask

  task automatic checkBusWrite(input logic [AddrWidth-1:0] addr, input wordT data,
                               input maskT mask);
    checkEq("wbAdr_o", 64'(lastWrAdr), 64'(addr));
    checkEq("wbDat_o", lastWrDat, data);
    checkEq("wbSel_o", 64'(lastWrSel), 64'(mask));
  endtask

  // responses come back in acceptance order
  always @(negedge clk) begin
    if (rst_n && dataOk) begin
      if (respCount >= expIsRead.size()) begin
        $display("dataOk_o pulsed at %0t with no request outstanding", $time);
        stopRun();
      end else begin
        if (expIsRead[respCount]) begin
          checkEq("rdData_o", rdData, expData[respCount]);
        end
        respCount = respCount + 1;
      end
    end
  end

  initial begin
    int                   waited;
    int                   gap;
    opT                   op;
    logic [AddrWidth-1:0] addr;
    void'($urandom(80));
    reqValid   = 1'b0;
    reqOp      = opRead;
    reqAddr    = '0;
    reqData    = '0;
    reqMask    = '0;
    expRefills = 0;
    for (int i = 0; i < MemWords; i++) begin
      shadowMem[i] = patternWord(32'(i * 8));
    end
    for (int s = 0; s < Sets; s++) begin
      shadowValid[s][0] = 1'b0;
      shadowValid[s][1] = 1'b0;
      shadowLru[s]      = 1'b0;
    end

    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      stopRun();
    end
    @(negedge clk);

    // idle after reset, then a first read misses
    checkEq("wbCyc_o", 64'(wbCyc), 64'd0);
    checkEq("wbStb_o", 64'(wbStb), 64'd0);
    checkEq("dataOk_o", 64'(dataOk), 64'd0);
    checkEq("addrOk_o", 64'(addrOk), 64'd1);
    sendReq(opRead, 32'h40, '0, '0, gap);
    drainResponses();
    checkEq("first miss bursts", 64'(bursts), 64'd1);
    checkRefills();

    // same line back to back at one request per edge
    for (int w = 0; w < LineWords; w++) begin
      sendReq(opRead, 32'h40 + 32'(((w + 1) % LineWords) * BeatBytes), '0, '0, gap);
      checkEq("accept stall", 64'(gap), 64'd0);
    end
    drainResponses();
    checkRefills();

    // masked writes to a cached and an uncached line
    sendReq(opWrite, 32'h50, 64'h1122_3344_5566_7788, 8'h0F, gap);
    drainResponses();
    checkBusWrite(32'h50, 64'h1122_3344_5566_7788, 8'h0F);
    sendReq(opRead, 32'h50, '0, '0, gap);
    sendReq(opWrite, 32'h1200, 64'hCAFE_F00D_1234_5678, 8'hF0, gap);
    drainResponses();
    checkBusWrite(32'h1200, 64'hCAFE_F00D_1234_5678, 8'hF0);
    sendReq(opRead, 32'h1200, '0, '0, gap);
    drainResponses();
    checkRefills();

    // three tags fighting over set 3
    sendReq(opRead, 32'h0060, '0, '0, gap);
    sendReq(opRead, 32'h0860, '0, '0, gap);
    sendReq(opRead, 32'h0060, '0, '0, gap);
    sendReq(opRead, 32'h1060, '0, '0, gap);
    sendReq(opRead, 32'h0860, '0, '0, gap);
    sendReq(opRead, 32'h0060, '0, '0, gap);
    drainResponses();
    checkRefills();

    // random mix over four tags and four sets
    for (int n = 0; n < RandomOps; n++) begin
      op   = ($urandom % 2 == 0) ? opRead : opWrite;
      addr = (($urandom % 4) << 11) | (($urandom % 4) << 5) | (($urandom % 4) << 3);
      sendReq(op, addr, {$urandom, $urandom}, maskT'($urandom), gap);
    end
    drainResponses();
    checkRefills();

    // back in idle with the bus released
    @(negedge clk);
    checkEq("addrOk_o", 64'(addrOk), 64'd1);
    checkEq("wbCyc_o", 64'(wbCyc), 64'd0);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/dcache2w_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dcache2w_assertions (
  input wire                                clk,
  input wire                                rst_n,
  input wire                                valid_i,
  input wire                                addrOk_i,
  input wire                                dataOk_i,
  input wire                                cyc_i,
  input wire                                stb_i,
  input wire                                ack_i,
  input wire [cacheGeomPkg::AddrWidth-1:0]  adr_i,
  input wire cacheBusPkg::wordT             dat_i,
  input wire cacheBusPkg::maskT             sel_i
);

  // accepted requests still waiting for their response
  int outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + ((valid_i && addrOk_i) ? 1 : 0) - (dataOk_i ? 1 : 0);
    end
  end

  stbNeedsCyc: assert property (@(posedge clk) disable iff (!rst_n) stb_i |-> cyc_i)
    else $error("wishbone STB high without CYC");

  beatHeld: assert property (@(posedge clk) disable iff (!rst_n)
    (stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(dat_i) && $stable(sel_i)))
    else $error("wishbone beat changed before ACK");

  respNeedsReq: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_i |-> (outstanding > 0))
    else $error("dataOk_o with no outstanding request");

endmodule

bind dcache2wTop dcache2w_assertions assertions_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .valid_i  (valid_i),
  .addrOk_i (addrOk_o),
  .dataOk_i (dataOk_o),
  .cyc_i    (wbCyc_o),
  .stb_i    (wbStb_o),
  .ack_i    (wbAck_i),
  .adr_i    (wbAdr_o),
  .dat_i    (wbDat_o),
  .sel_i    (wbSel_o)
);

`default_nettype wire

//--- tests/wbMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module wbMemModel #(
  parameter int Words = 2048
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                wbCyc_i,
  input  wire                                wbStb_i,
  input  wire                                wbWe_i,
  input  wire [cacheGeomPkg::AddrWidth-1:0]  wbAdr_i,
  input  wire cacheBusPkg::wordT             wbDat_i,
  input  wire cacheBusPkg::maskT             wbSel_i,
  output cacheBusPkg::wordT                  wbDat_o,
  output logic                               wbAck_o,
  output int                                 bursts_o,
  output int                                 readBeats_o,
  output logic [cacheGeomPkg::AddrWidth-1:0] lastWrAdr_o,
  output cacheBusPkg::wordT                  lastWrDat_o,
  output cacheBusPkg::maskT                  lastWrSel_o
);

  import cacheBusPkg::*;

  localparam int IdxBits = $clog2(Words);

  wordT               mem [Words];
  logic [1:0]         waitLeft;
  logic               cycSeen;
  logic [IdxBits-1:0] idx;

  assign idx = wbAdr_i[3 +: IdxBits];

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbAck_o     <= 1'b0;
      waitLeft    <= 2'd0;
      cycSeen     <= 1'b0;
      bursts_o    <= 0;
      readBeats_o <= 0;
      // every word seeded from its own byte address
      for (int i = 0; i < Words; i++) begin
        mem[i] <= {32'(i * 8) ^ 32'h5EED_F00D, ~32'(i * 8)};
      end
    end else begin
      wbAck_o <= 1'b0;
      cycSeen <= wbCyc_i;
      // a read cycle opening is one refill burst
      if (wbCyc_i && !cycSeen && !wbWe_i) begin
        bursts_o <= bursts_o + 1;
      end
      if (wbCyc_i && wbStb_i && !wbAck_o) begin
        if (waitLeft != 2'd0) begin
          waitLeft <= waitLeft - 2'd1;
        end else begin
          wbAck_o  <= 1'b1;
          waitLeft <= 2'($urandom % 4);
          if (wbWe_i) begin
            for (int b = 0; b < MaskWidth; b++) begin
              if (wbSel_i[b]) begin
                mem[idx][b*8 +: 8] <= wbDat_i[b*8 +: 8];
              end
            end
            lastWrAdr_o <= wbAdr_i;
            lastWrDat_o <= wbDat_i;
            lastWrSel_o <= wbSel_i;
          end else begin
            wbDat_o     <= mem[idx];
            readBeats_o <= readBeats_o + 1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int HalfPeriod  = 2,
  parameter int ResetCycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // reset let go on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/dcache2wTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcache2wTop (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                valid_i,
  input  wire cacheBusPkg::opT               op_i,
  input  wire [cacheGeomPkg::AddrWidth-1:0]  addr_i,
  input  wire cacheBusPkg::wordT             wrData_i,
  input  wire cacheBusPkg::maskT             wrMask_i,
  output logic                               addrOk_o,
  output logic                               dataOk_o,
  output cacheBusPkg::wordT                  rdData_o,
  output logic                               wbCyc_o,
  output logic                               wbStb_o,
  output logic                               wbWe_o,
  output logic [cacheGeomPkg::AddrWidth-1:0] wbAdr_o,
  output cacheBusPkg::wordT                  wbDat_o,
  output cacheBusPkg::maskT                  wbSel_o,
  input  wire cacheBusPkg::wordT             wbDat_i,
  input  wire                                wbAck_i
);

  import cacheGeomPkg::*;
  import cacheBusPkg::*;

  logic                   rdEn;
  indexT                  rdIndex;
  tagT                    tag0;
  tagT                    tag1;
  logic                   valid0;
  logic                   valid1;
  logic                   tagWe;
  logic                   tagWay;
  indexT                  tagIndex;
  tagT                    tagData;
  lineT                   line0;
  lineT                   line1;
  logic                   lineWe;
  logic                   lineWay;
  indexT                  lineIndex;
  logic [WordSelBits-1:0] lineWord;
  wordT                   lineData;
  maskT                   lineMask;
  logic                   refillStart;
  logic                   writeStart;
  logic [AddrWidth-1:0]   memAddr;
  wordT                   memData;
  maskT                   memMask;
  logic                   refillWordValid;
  logic [WordSelBits-1:0] refillWord;
  wordT                   refillData;
  logic                   memDone;

  cacheCtrl ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (valid_i),
    .op_i              (op_i),
    .addr_i            (addr_i),
    .wrData_i          (wrData_i),
    .wrMask_i          (wrMask_i),
    .addrOk_o          (addrOk_o),
    .dataOk_o          (dataOk_o),
    .rdData_o          (rdData_o),
    .rdEn_o            (rdEn),
    .rdIndex_o         (rdIndex),
    .tag0_i            (tag0),
    .tag1_i            (tag1),
    .valid0_i          (valid0),
    .valid1_i          (valid1),
    .tagWe_o           (tagWe),
    .tagWay_o          (tagWay),
    .tagIndex_o        (tagIndex),
    .tagData_o         (tagData),
    .line0_i           (line0),
    .line1_i           (line1),
    .lineWe_o          (lineWe),
    .lineWay_o         (lineWay),
    .lineIndex_o       (lineIndex),
    .lineWord_o        (lineWord),
    .lineData_o        (lineData),
    .lineMask_o        (lineMask),
    .refillStart_o     (refillStart),
    .writeStart_o      (writeStart),
    .memAddr_o         (memAddr),
    .memData_o         (memData),
    .memMask_o         (memMask),
    .refillWordValid_i (refillWordValid),
    .refillWord_i      (refillWord),
    .refillData_i      (refillData),
    .memDone_i         (memDone)
  );

  tagStore tags_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdEn_i    (rdEn),
    .rdIndex_i (rdIndex),
    .we_i      (tagWe),
    .way_i     (tagWay),
    .wrIndex_i (tagIndex),
    .wrTag_i   (tagData),
    .tag0_o    (tag0),
    .tag1_o    (tag1),
    .valid0_o  (valid0),
    .valid1_o  (valid1)
  );

  lineStore lines_i (
    .clk       (clk),
    .rdEn_i    (rdEn),
    .rdIndex_i (rdIndex),
    .we_i      (lineWe),
    .way_i     (lineWay),
    .wrIndex_i (lineIndex),
    .wrWord_i  (lineWord),
    .wrData_i  (lineData),
    .wrMask_i  (lineMask),
    .line0_o   (line0),
    .line1_o   (line1)
  );

  wbMemPort mem_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .refillStart_i (refillStart),
    .writeStart_i  (writeStart),
    .addr_i        (memAddr),
    .data_i        (memData),
    .mask_i        (memMask),
    .wbCyc_o       (wbCyc_o),
    .wbStb_o       (wbStb_o),
    .wbWe_o        (wbWe_o),
    .wbAdr_o       (wbAdr_o),
    .wbDat_o       (wbDat_o),
    .wbSel_o       (wbSel_o),
    .wbDat_i       (wbDat_i),
    .wbAck_i       (wbAck_i),
    .wordValid_o   (refillWordValid),
    .word_o        (refillWord),
    .wordData_o    (refillData),
    .done_o        (memDone)
  );

endmodule

`default_nettype wire

//--- logic/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  wire                                  clk,
  input  wire                                  rst_n,
  // pipeline request and response
  input  wire                                  valid_i,
  input  wire cacheBusPkg::opT                 op_i,
  input  wire [cacheGeomPkg::AddrWidth-1:0]    addr_i,
  input  wire cacheBusPkg::wordT               wrData_i,
  input  wire cacheBusPkg::maskT               wrMask_i,
  output logic                                 addrOk_o,
  output logic                                 dataOk_o,
  output cacheBusPkg::wordT                    rdData_o,
  // store read port
  output logic                                 rdEn_o,
  output cacheGeomPkg::indexT                  rdIndex_o,
  input  wire cacheGeomPkg::tagT               tag0_i,
  input  wire cacheGeomPkg::tagT               tag1_i,
  input  wire                                  valid0_i,
  input  wire                                  valid1_i,
  output logic                                 tagWe_o,
  output logic                                 tagWay_o,
  output cacheGeomPkg::indexT                  tagIndex_o,
  output cacheGeomPkg::tagT                    tagData_o,
  input  wire cacheBusPkg::lineT               line0_i,
  input  wire cacheBusPkg::lineT               line1_i,
  output logic                                 lineWe_o,
  output logic                                 lineWay_o,
  output cacheGeomPkg::indexT                  lineIndex_o,
  output logic [cacheGeomPkg::WordSelBits-1:0] lineWord_o,
  output cacheBusPkg::wordT                    lineData_o,
  output cacheBusPkg::maskT                    lineMask_o,
  // memory port
  output logic                                 refillStart_o,
  output logic                                 writeStart_o,
  output logic [cacheGeomPkg::AddrWidth-1:0]   memAddr_o,
  output cacheBusPkg::wordT                    memData_o,
  output cacheBusPkg::maskT                    memMask_o,
  input  wire                                  refillWordValid_i,
  input  wire [cacheGeomPkg::WordSelBits-1:0]  refillWord_i,
  input  wire cacheBusPkg::wordT               refillData_i,
  input  wire                                  memDone_i
);

  import cacheGeomPkg::*;
  import cacheBusPkg::*;

  localparam logic [2:0] StIdle     = 3'd0;
  localparam logic [2:0] StLookup   = 3'd1;
  localparam logic [2:0] StRefill   = 3'd2;
  localparam logic [2:0] StInstall  = 3'd3;
  localparam logic [2:0] StReplay   = 3'd4;
  localparam logic [2:0] StMemWrite = 3'd5;

  logic [2:0]      state;
  logic [2:0]      nextState;
  cacheAddr_u      inAddr;
  cacheAddr_u      reqAddr;
  opT              reqOp;
  wordT            reqData;
  maskT            reqMask;
  logic [Sets-1:0] lru;
  logic            victim;
  logic            pickWay;
  logic            hit0;
  logic            hit1;
  logic            hit;
  logic            accept;
  logic            inLookup;
  logic            inRefill;

  assign inAddr.raw = addr_i;
  assign inLookup   = state == StLookup;
  assign inRefill   = state == StRefill;

  // hit check against the lookup registered by the stores
  assign hit0 = valid0_i && (tag0_i == reqAddr.f.tag);
  assign hit1 = valid1_i && (tag1_i == reqAddr.f.tag);
  assign hit  = hit0 || hit1;

  // invalid way first, otherwise the set's LRU way
  assign pickWay = !valid0_i ? 1'b0 : (!valid1_i ? 1'b1 : lru[reqAddr.f.index]);

  // a read hit answers and can take the next request in the same cycle
  assign addrOk_o = (state == StIdle) || (inLookup && reqOp == opRead && hit);
  assign accept   = valid_i && addrOk_o;
  assign dataOk_o = (inLookup && reqOp == opRead && hit) ||
                    (state == StMemWrite && memDone_i);
  assign rdData_o = hit1 ? line1_i[reqAddr.f.wordSel*DataWidth +: DataWidth]
                         : line0_i[reqAddr.f.wordSel*DataWidth +: DataWidth];

  // replay re-reads the latched index after install
  assign rdEn_o    = accept || (state == StReplay);
  assign rdIndex_o = (state == StReplay) ? reqAddr.f.index : inAddr.f.index;

  assign tagWe_o    = state == StInstall;
  assign tagWay_o   = victim;
  assign tagIndex_o = reqAddr.f.index;
  assign tagData_o  = reqAddr.f.tag;

  // refill words stream in, write hits merge under the mask
  assign lineWe_o    = (inRefill && refillWordValid_i) || (inLookup && reqOp == opWrite && hit);
  assign lineWay_o   = inRefill ? victim : hit1;
  assign lineIndex_o = reqAddr.f.index;
  assign lineWord_o  = inRefill ? refillWord_i : reqAddr.f.wordSel;
  assign lineData_o  = inRefill ? refillData_i : reqData;
  assign lineMask_o  = inRefill ? FullMask : reqMask;

  assign refillStart_o = inLookup && reqOp == opRead && !hit;
  assign writeStart_o  = inLookup && reqOp == opWrite;
  assign memAddr_o     = reqAddr.raw;
  assign memData_o     = reqData;
  assign memMask_o     = reqMask;

  always_comb begin
    nextState = state;
    case (state)
      StIdle: begin
        if (accept) begin
          nextState = StLookup;
        end
      end
      StLookup: begin
        if (reqOp == opWrite) begin
          nextState = StMemWrite;
        end else if (!hit) begin
          nextState = StRefill;
        end else if (!accept) begin
          nextState = StIdle;
        end
      end
      StRefill: begin
        if (memDone_i) begin
          nextState = StInstall;
        end
      end
      StInstall: nextState = StReplay;
      StReplay:  nextState = StLookup;
      StMemWrite: begin
        if (memDone_i) begin
          nextState = StIdle;
        end
      end
      default: nextState = StIdle;
    endcase
  end

  // lru bit names the way to evict next
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= StIdle;
      lru   <= '0;
    end else begin
      state <= nextState;
      if (inLookup && hit) begin
        lru[reqAddr.f.index] <= hit0;
      end else if (state == StInstall) begin
        lru[reqAddr.f.index] <= ~victim;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr.raw <= addr_i;
      reqOp       <= op_i;
      reqData     <= wrData_i;
      reqMask     <= wrMask_i;
    end
    if (refillStart_o) begin
      victim <= pickWay;
    end
  end

endmodule

`default_nettype wire

//--- logic/wbMemPort.sv
`timescale 1ns/1ps
`default_nettype none

module wbMemPort (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 refillStart_i,
  input  wire                                 writeStart_i,
  input  wire [cacheGeomPkg::AddrWidth-1:0]   addr_i,
  input  wire cacheBusPkg::wordT              data_i,
  input  wire cacheBusPkg::maskT              mask_i,
  output logic                                wbCyc_o,
  output logic                                wbStb_o,
  output logic                                wbWe_o,
  output logic [cacheGeomPkg::AddrWidth-1:0]  wbAdr_o,
  output cacheBusPkg::wordT                   wbDat_o,
  output cacheBusPkg::maskT                   wbSel_o,
  input  wire cacheBusPkg::wordT              wbDat_i,
  input  wire                                 wbAck_i,
  output logic                                wordValid_o,
  output logic [cacheGeomPkg::WordSelBits-1:0] word_o,
  output cacheBusPkg::wordT                   wordData_o,
  output logic                                done_o
);

  import cacheGeomPkg::*;
  import cacheBusPkg::*;

  cacheAddr_u             busAdr;
  logic [WordSelBits-1:0] beat;
  logic                   launch;
  logic                   beatDone;
  logic                   lastBeat;

  assign launch   = !wbCyc_o && (refillStart_i || writeStart_i);
  assign beatDone = wbCyc_o && wbAck_i;
  // a write is a single beat, a refill ends on its fourth ack
  assign lastBeat = wbWe_o || (beat == WordSelBits'(RefillBeats - 1));
  assign wbAdr_o  = busAdr.raw;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbCyc_o     <= 1'b0;
      wbStb_o     <= 1'b0;
      wbWe_o      <= 1'b0;
      beat        <= '0;
      wordValid_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      wordValid_o <= beatDone && !wbWe_o;
      done_o      <= beatDone && lastBeat;
      if (launch) begin
        wbCyc_o <= 1'b1;
        wbStb_o <= 1'b1;
        wbWe_o  <= writeStart_i;
        beat    <= '0;
      end else if (beatDone) begin
        beat <= beat + 1'b1;
        if (lastBeat) begin
          wbCyc_o <= 1'b0;
          wbStb_o <= 1'b0;
        end
      end
    end
  end

  // refills start at the line base with the offset cleared
  always_ff @(posedge clk) begin
    if (launch) begin
      busAdr.raw <= refillStart_i ? {addr_i[AddrWidth-1:OffsetBits], OffsetBits'(0)} : addr_i;
      wbDat_o    <= data_i;
      wbSel_o    <= refillStart_i ? FullMask : mask_i;
    end else if (beatDone && !wbWe_o) begin
      busAdr.raw <= busAdr.raw + AddrWidth'(BeatBytes);
    end
    if (beatDone) begin
      word_o     <= beat;
      wordData_o <= wbDat_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/lineStore.sv
`timescale 1ns/1ps
`default_nettype none

module lineStore (
  input  wire                                     clk,
  input  wire                                     rdEn_i,
  input  wire cacheGeomPkg::indexT                rdIndex_i,
  input  wire                                     we_i,
  input  wire                                     way_i,
  input  wire cacheGeomPkg::indexT                wrIndex_i,
  input  wire [cacheGeomPkg::WordSelBits-1:0]     wrWord_i,
  input  wire cacheBusPkg::wordT                  wrData_i,
  input  wire cacheBusPkg::maskT                  wrMask_i,
  output cacheBusPkg::lineT                       line0_o,
  output cacheBusPkg::lineT                       line1_o
);

  import cacheGeomPkg::*;
  import cacheBusPkg::*;

  localparam int ByteBits = DataWidth / MaskWidth;

  // way, set, word within the line
  wordT mem [2][Sets][LineWords];

  // word write under the byte mask, full mask on refill
  always_ff @(posedge clk) begin
    for (int b = 0; b < MaskWidth; b++) begin
      if (we_i && wrMask_i[b]) begin
        mem[way_i][wrIndex_i][wrWord_i][b*ByteBits +: ByteBits] <=
          wrData_i[b*ByteBits +: ByteBits];
      end
    end
  end

  // both ways return a whole line one cycle after the enable
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      for (int w = 0; w < LineWords; w++) begin
        line0_o[w*DataWidth +: DataWidth] <= mem[0][rdIndex_i][w];
        line1_o[w*DataWidth +: DataWidth] <= mem[1][rdIndex_i][w];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  rdEn_i,
  input  wire cacheGeomPkg::indexT rdIndex_i,
  input  wire                  we_i,
  input  wire                  way_i,
  input  wire cacheGeomPkg::indexT wrIndex_i,
  input  wire cacheGeomPkg::tagT   wrTag_i,
  output cacheGeomPkg::tagT        tag0_o,
  output cacheGeomPkg::tagT        tag1_o,
  output logic                 valid0_o,
  output logic                 valid1_o
);

  import cacheGeomPkg::*;

  tagT             tags  [2][Sets];
  logic [Sets-1:0] valid [2];

  // tag arrays with registered read data
  always_ff @(posedge clk) begin
    if (we_i) begin
      tags[way_i][wrIndex_i] <= wrTag_i;
    end
    if (rdEn_i) begin
      tag0_o <= tags[0][rdIndex_i];
      tag1_o <= tags[1][rdIndex_i];
    end
  end

  // valid bits start cleared, a tag write marks its way valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid[0] <= '0;
      valid[1] <= '0;
      valid0_o <= 1'b0;
      valid1_o <= 1'b0;
    end else begin
      if (we_i) begin
        valid[way_i][wrIndex_i] <= 1'b1;
      end
      if (rdEn_i) begin
        valid0_o <= valid[0][rdIndex_i];
        valid1_o <= valid[1][rdIndex_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/cacheBusPkg.sv
`default_nettype none

package cacheBusPkg;

  localparam int DataWidth = 64;
  localparam int MaskWidth = 8;

  // wishbone beats per line refill, byte stride between beats
  localparam int RefillBeats = 4;
  localparam int BeatBytes   = 8;

  typedef logic [DataWidth-1:0]             wordT;
  typedef logic [MaskWidth-1:0]             maskT;
  typedef logic [RefillBeats*DataWidth-1:0] lineT;

  localparam maskT FullMask = '1;

  typedef enum logic {
    opRead  = 1'b0,
    opWrite = 1'b1
  } opT;

endpackage

`default_nettype wire

//--- logic/cacheGeomPkg.sv
`default_nettype none

package cacheGeomPkg;

  // address splits into tag, index, word in line and byte in word
  localparam int AddrWidth   = 32;
  localparam int TagBits     = 21;
  localparam int IndexBits   = 6;
  localparam int OffsetBits  = 5;
  localparam int Sets        = 64;
  localparam int LineWords   = 4;
  localparam int WordSelBits = 2;

  typedef logic [TagBits-1:0]   tagT;
  typedef logic [IndexBits-1:0] indexT;

  // raw bus address or decoded cache fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      tagT                               tag;
      indexT                             index;
      logic [WordSelBits-1:0]            wordSel;
      logic [OffsetBits-WordSelBits-1:0] byteSel;
    } f;
  } cacheAddr_u;

endpackage

`default_nettype wire
